// File: list.f
source/sensor_pkg.sv
source/sensor_sequencer.sv
source/touch_port.sv
source/ecg_port.sv
source/uart_wb_tx.sv
source/sensor_core.sv
bench/sensor_models.sv
bench/sensor_core_tb.sv

// File: Bender.yml
package:
  name: sensor_core

sources:
  - source/sensor_pkg.sv
  - source/sensor_sequencer.sv
  - source/touch_port.sv
  - source/ecg_port.sv
  - source/uart_wb_tx.sv
  - source/sensor_core.sv
  - target: test
    files:
      - bench/sensor_models.sv
      - bench/sensor_core_tb.sv

// File: bench/sensor_core_tb.sv
// Fixed-seed random run of setup, run, ADC and touch streaming and stop; ends by max_cycles at latest
`timescale 1ns/1ps
module sensor_core_tb;
	localparam int run_cycles = 15000; // Acquisition time before stop
	localparam int quiet_cycles = 2000; // Watch for stray bytes after stop
	localparam int setup_budget = 3000;
	localparam int max_cycles = 2 * (setup_budget + run_cycles + quiet_cycles);

	logic clk = 1'b0;
	logic rst;
	logic run;
	sensor_pkg::reg_addr_t mpr_addr, ads_addr;
	sensor_pkg::reg_data_t mpr_wdata, mpr_rdata, ads_wdata;
	logic mpr_write, mpr_read, mpr_busy, mpr_fail;
	sensor_pkg::ads_cmd_t ads_cmd;
	logic ads_busy, ads_ready;
	sensor_pkg::ecg_frame_t ads_frame;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	logic [2:0] wb_adr;
	logic [7:0] wb_dat;
	logic ready, running, touch_error;
	sensor_pkg::touch_status_t touch_status;

	logic [17:0] exp_ops[$]; // {kind, addr, data}; 0 touch write, 1 WREG, 2 RDATAC, 3 SDATAC
	sensor_pkg::ecg_frame_t ecg_q[$];
	logic [15:0] touch_q[$]; // {low byte, masked high byte}
	int errs[1:6];
	int phase, cycles, setup_seen, frames_sent, polls_sent, fails_seen;
	int cur_left, cur_kind; // Frame now on the UART
	logic [79:0] cur_bytes;
	logic rd_hi, rd_active, mpr_busy_q, ads_ready_q, err_exp, stb_q, ack_q;
	logic [7:0] dat_q, lo_q;

	always #10 clk = ~clk;

	sensor_core #(.touch_poll_cycles(32'd300)) uut (
		.clk, .rst, .run,
		.mpr_addr, .mpr_wdata, .mpr_write, .mpr_read, .mpr_rdata, .mpr_busy, .mpr_fail,
		.ads_cmd, .ads_addr, .ads_wdata, .ads_busy, .ads_frame, .ads_ready,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat, .wb_ack,
		.ready, .running, .touch_status, .touch_error
	);

	sensor_models u_models (
		.clk, .rst, .mpr_write, .mpr_read, .mpr_rdata, .mpr_busy, .mpr_fail,
		.ads_cmd, .ads_busy, .ads_frame, .ads_ready, .wb_cyc, .wb_stb, .wb_ack
	);

	task automatic flag_error(input int test, input string line);
		$display("%s", line);
		errs[test]++;
	endtask

	// Header byte picks the frame kind, later bytes follow it MSB first
	task automatic match_uart_byte(input logic [7:0] b);
		if (cur_left == 0) begin
			assert ((b == sensor_pkg::hdr_ecg && ecg_q.size() > 0) ||
				(b == sensor_pkg::hdr_touch && touch_q.size() > 0))
			else flag_error((phase < 3 || phase == 6) ? phase : 3,
				$sformatf("Fail at %0t ns: UART byte %h starts no expected frame", $time, b));
			if (b == sensor_pkg::hdr_ecg && ecg_q.size() > 0) begin
				cur_bytes = {ecg_q.pop_front(), 8'h00};
				cur_left = 9;
				cur_kind = 3;
			end else if (b == sensor_pkg::hdr_touch && touch_q.size() > 0) begin
				assert (touch_status == {touch_q[0][3:0], touch_q[0][15:8]})
				else flag_error(4, $sformatf("Fail at %0t ns: touch_status %h, expected %h",
					$time, touch_status, {touch_q[0][3:0], touch_q[0][15:8]}));
				cur_bytes = {touch_q.pop_front(), 64'h0};
				cur_left = 2;
				cur_kind = 4;
			end
		end else begin
			assert (b == cur_bytes[79:72]) else flag_error(cur_kind,
				$sformatf("Fail at %0t ns: UART byte %h, expected %h", $time, b, cur_bytes[79:72]));
			cur_bytes = {cur_bytes[71:0], 8'h00};
			cur_left--;
			if (cur_left == 0 && cur_kind == 3) frames_sent++;
			if (cur_left == 0 && cur_kind == 4) polls_sent++;
		end
	endtask

	// Reference model and checks, sampled on the rising edge
	always @(posedge clk) begin : monitor
		logic [17:0] got, want;
		if (!rst) begin
			if (mpr_write || ads_cmd != sensor_pkg::cmd_idle) begin
				if (mpr_write) got = {2'd0, mpr_addr, mpr_wdata};
				else if (ads_cmd == sensor_pkg::cmd_wreg) got = {2'd1, ads_addr, ads_wdata};
				else if (ads_cmd == sensor_pkg::cmd_rdatac) got = {2'd2, 16'h0};
				else got = {2'd3, 16'h0}; // SDATAC or a stray code
				assert (exp_ops.size() > 0)
				else flag_error(phase, $sformatf("Unexpected sensor operation %h", got));
				if (exp_ops.size() > 0) begin
					want = exp_ops.pop_front();
					assert (got == want) else flag_error(phase,
						$sformatf("Fail at %0t ns: sensor op %h, expected %h", $time, got, want));
					if (phase == 1) setup_seen++;
				end
			end
			assert (!ready || setup_seen == sensor_pkg::setup_len)
			else flag_error(1, "ready rose before the setup table was written");
			if (mpr_read) begin
				assert (mpr_addr == (rd_hi ? sensor_pkg::touch_status_hi : sensor_pkg::touch_status_lo))
				else flag_error(4, $sformatf("Fail at %0t ns: status read of %h", $time, mpr_addr));
			end
			if (mpr_write || mpr_read) rd_active = mpr_read;
			assert (touch_error == err_exp) else flag_error(5,
				$sformatf("Fail at %0t ns: touch_error %b, expected %b", $time, touch_error, err_exp));
			if (mpr_busy_q && !mpr_busy && rd_active) begin
				if (mpr_fail) begin
					fails_seen++;
					rd_hi = 1'b0; // Poll dropped, flag stays
					err_exp = 1'b1;
				end else if (!rd_hi) begin
					lo_q = mpr_rdata;
					rd_hi = 1'b1;
				end else begin
					touch_q.push_back({lo_q, 4'h0, mpr_rdata[3:0]});
					rd_hi = 1'b0;
				end
			end
			if (ads_ready && !ads_ready_q) ecg_q.push_back(ads_frame); // New frame
			if (stb_q && !ack_q) begin
				assert (wb_cyc && wb_stb && wb_dat == dat_q) else flag_error(3,
					$sformatf("Fail at %0t ns: Wishbone write changed before ack", $time));
			end
			if (ack_q) begin
				assert (!wb_stb) else flag_error(3, "Wishbone strobe stayed up between two bytes");
			end
			if (wb_cyc && wb_stb && wb_ack) begin
				assert (wb_we && wb_adr == sensor_pkg::uart_tx_adr) else flag_error(3,
					$sformatf("Fail at %0t ns: write to UART offset %0d", $time, wb_adr));
				match_uart_byte(wb_dat);
			end
		end
		mpr_busy_q = mpr_busy;
		ads_ready_q = ads_ready;
		stb_q = wb_cyc && wb_stb;
		ack_q = wb_ack;
		dat_q = wb_dat;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Run stopped, no end after %0d clock cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		int seed_draw;
		int sent;
		int total;
		int failed;
		seed_draw = $urandom(32'h6058_8d32);
		rst = 1'b1;
		run = 1'b0;
		phase = 1;
		rd_hi = 1'b0;
		rd_active = 1'b0;
		err_exp = 1'b0;
		cur_left = 0;
		cur_kind = 0;
		for (int i = 0; i < sensor_pkg::setup_len; i++)
			exp_ops.push_back({(i < sensor_pkg::touch_setup_len) ? 2'd0 : 2'd1,
				sensor_pkg::setup_addr(5'(i)), sensor_pkg::setup_data(5'(i))});
		repeat (4) @(negedge clk);
		rst = 1'b0;
		while (!ready) @(negedge clk);
		assert (setup_seen == sensor_pkg::setup_len && exp_ops.size() == 0)
		else flag_error(1, "Setup writes were missing when ready rose");
		$display("Test 1 setup: %0d writes, %0d errors", setup_seen, errs[1]);
		phase = 2;
		exp_ops.push_back({2'd0, sensor_pkg::touch_ele_config, sensor_pkg::ele_run});
		exp_ops.push_back({2'd2, 16'h0});
		run = 1'b1;
		while (!running) @(negedge clk);
		assert (exp_ops.size() == 0) else flag_error(2, "running rose before the start sequence");
		$display("Test 2 run start: %0d errors", errs[2]);
		phase = 3;
		repeat (run_cycles) @(negedge clk);
		sent = frames_sent;
		while (frames_sent == sent) @(negedge clk); // Stop right after an ADC frame
		assert (ecg_q.size() == 0) else flag_error(3,
			$sformatf("%0d captured ADC frames never reached the UART", ecg_q.size()));
		$display("Test 3 ADC frames: %0d frames, %0d errors", frames_sent, errs[3]);
		assert (polls_sent > 0) else flag_error(4, "No touch status frame reached the UART");
		$display("Test 4 touch polls: %0d frames, %0d errors", polls_sent, errs[4]);
		assert (fails_seen == 1 && touch_error) else flag_error(5,
			$sformatf("Expected one failed touch read with touch_error set, saw %0d", fails_seen));
		$display("Test 5 touch fail: %0d failed reads, %0d errors", fails_seen, errs[5]);
		phase = 6;
		exp_ops.push_back({2'd0, sensor_pkg::touch_ele_config, sensor_pkg::ele_stop});
		exp_ops.push_back({2'd3, 16'h0});
		run = 1'b0;
		while (running) @(negedge clk);
		repeat (quiet_cycles) @(negedge clk);
		assert (exp_ops.size() == 0 && cur_left == 0 && ecg_q.size() == 0 && touch_q.size() == 0)
		else flag_error(6, "Expected sensor writes or UART bytes never arrived");
		$display("Test 6 run stop: %0d errors", errs[6]);
		total = 0;
		failed = 0;
		for (int t = 1; t <= 6; t++) begin
			total += errs[t];
			if (errs[t] > 0) failed++;
		end
		$display("Tests: 6, failed: %0d, errors: %0d", failed, total);
		if (total == 0) $display("Finished with no errors");
		else $display("Finished with errors");
		$finish;
	end

endmodule

// File: bench/sensor_models.sv
// Behavioral touch chip, ADC and UART slave; exactly one touch status read fails, frames only after RDATAC
`timescale 1ns/1ps
module sensor_models (
	input logic clk,
	input logic rst,
	input logic mpr_write,
	input logic mpr_read,
	output sensor_pkg::reg_data_t mpr_rdata,
	output logic mpr_busy,
	output logic mpr_fail,
	input sensor_pkg::ads_cmd_t ads_cmd,
	output logic ads_busy,
	output sensor_pkg::ecg_frame_t ads_frame,
	output logic ads_ready,
	input logic wb_cyc,
	input logic wb_stb,
	output logic wb_ack
);
	int mpr_left;
	int ads_left;
	int ack_left;
	int ack_delay; // Drawn per byte
	int gap; // Cycles to the next frame
	int hold; // Cycles of ready left
	int reads;
	int fail_at; // Status read that fails
	logic is_read;
	logic streaming;
	logic ack_wait;

	initial begin
		mpr_rdata = '0;
		mpr_busy = 1'b0;
		mpr_fail = 1'b0;
		ads_busy = 1'b0;
		ads_frame = '0;
		ads_ready = 1'b0;
		wb_ack = 1'b0;
		streaming = 1'b0;
		ack_wait = 1'b0;
		hold = 0;
	end

	// Touch chip, busy 1 to 6 cycles
	always @(negedge clk) begin
		if (rst) begin
			mpr_busy <= 1'b0;
			mpr_fail <= 1'b0;
			reads <= 0;
			fail_at <= 4 + $urandom % 20;
		end else if (mpr_write || mpr_read) begin
			mpr_busy <= 1'b1;
			mpr_left <= 1 + $urandom % 6;
			is_read <= mpr_read;
		end else if (mpr_busy) begin
			if (mpr_left > 1) mpr_left <= mpr_left - 1;
			else begin
				mpr_busy <= 1'b0; // Result valid from here on
				mpr_rdata <= 8'($urandom);
				mpr_fail <= is_read && (reads + 1 == fail_at);
				if (is_read) reads <= reads + 1;
			end
		end
	end

	// ADC register write
	always @(negedge clk) begin
		if (rst) ads_busy <= 1'b0;
		else if (ads_cmd == sensor_pkg::cmd_wreg) begin
			ads_busy <= 1'b1;
			ads_left <= 1 + $urandom % 6;
		end else if (ads_busy) begin
			if (ads_left > 1) ads_left <= ads_left - 1;
			else ads_busy <= 1'b0;
		end
	end

	// Continuous read, ready high 4 cycles per frame
	always @(negedge clk) begin
		if (rst || ads_cmd == sensor_pkg::cmd_sdatac) begin
			streaming <= 1'b0;
			ads_ready <= 1'b0;
			hold <= 0;
		end else if (ads_cmd == sensor_pkg::cmd_rdatac) begin
			streaming <= 1'b1;
			gap <= 600 + $urandom % 300;
		end else if (streaming) begin
			if (hold > 0) begin
				hold <= hold - 1;
				if (hold == 1) ads_ready <= 1'b0;
			end
			if (gap == 0) begin
				ads_frame <= {8'($urandom), $urandom, $urandom};
				ads_ready <= 1'b1;
				hold <= 4;
				gap <= 600 + $urandom % 300; // At least 600 apart
			end else gap <= gap - 1;
		end
	end

	// UART slave, ack after 0 to 4 cycles
	always @(negedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			ack_wait <= 1'b0;
		end else if (wb_ack || !(wb_cyc && wb_stb)) begin
			wb_ack <= 1'b0; // Single-cycle ack
			ack_wait <= 1'b0;
		end else if (!ack_wait) begin
			ack_delay = $urandom % 5;
			if (ack_delay == 0) wb_ack <= 1'b1;
			else begin
				ack_left <= ack_delay;
				ack_wait <= 1'b1;
			end
		end else if (ack_left > 1) ack_left <= ack_left - 1;
		else begin
			wb_ack <= 1'b1;
			ack_wait <= 1'b0;
		end
	end

endmodule

// File: source/sensor_core.sv
// Sensor front end top; touch_poll_cycles sets the touch poll period in clk cycles
`timescale 1ns/1ps
module sensor_core #(
	parameter logic [31:0] touch_poll_cycles = 32'd10000
) (
	input logic clk,
	input logic rst,
	input logic run,
	output sensor_pkg::reg_addr_t mpr_addr,
	output sensor_pkg::reg_data_t mpr_wdata,
	output logic mpr_write,
	output logic mpr_read,
	input sensor_pkg::reg_data_t mpr_rdata,
	input logic mpr_busy,
	input logic mpr_fail,
	output sensor_pkg::ads_cmd_t ads_cmd,
	output sensor_pkg::reg_addr_t ads_addr,
	output sensor_pkg::reg_data_t ads_wdata,
	input logic ads_busy,
	input sensor_pkg::ecg_frame_t ads_frame,
	input logic ads_ready,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [2:0] wb_adr,
	output logic [7:0] wb_dat,
	input logic wb_ack,
	output logic ready,
	output logic running,
	output sensor_pkg::touch_status_t touch_status,
	output logic touch_error
);
	logic touch_wr_req, touch_rd_req, touch_done, touch_ok;
	sensor_pkg::reg_addr_t touch_addr, ecg_addr;
	sensor_pkg::reg_data_t touch_data, ecg_data;
	logic [15:0] touch_bytes;
	logic ecg_wr_req, ecg_start, ecg_stop, ecg_done;
	logic frame_pending, frame_taken;
	sensor_pkg::ecg_frame_t frame;
	logic tx_start, tx_done;
	sensor_pkg::payload_t tx_payload;
	sensor_pkg::byte_count_t tx_count;

	sensor_sequencer #(.touch_poll_cycles(touch_poll_cycles)) u_seq (
		.clk, .rst, .run,
		.touch_wr_req, .touch_rd_req, .touch_addr, .touch_data,
		.touch_done, .touch_ok, .touch_bytes,
		.ecg_wr_req, .ecg_start, .ecg_stop, .ecg_addr, .ecg_data,
		.ecg_done, .frame_pending, .frame, .frame_taken,
		.tx_start, .tx_payload, .tx_count, .tx_done,
		.ready, .running
	);

	touch_port u_touch (
		.clk, .rst,
		.touch_wr_req, .touch_rd_req, .touch_addr, .touch_data,
		.touch_done, .touch_ok, .touch_bytes, .touch_status, .touch_error,
		.mpr_addr, .mpr_wdata, .mpr_write, .mpr_read,
		.mpr_rdata, .mpr_busy, .mpr_fail
	);

	ecg_port u_ecg (
		.clk, .rst,
		.ecg_wr_req, .ecg_start, .ecg_stop, .ecg_addr, .ecg_data, .frame_taken,
		.ecg_done, .frame_pending, .frame,
		.ads_cmd, .ads_addr, .ads_wdata, .ads_busy, .ads_frame, .ads_ready
	);

	uart_wb_tx u_uart (
		.clk, .rst,
		.tx_start, .tx_payload, .tx_count, .tx_done,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat, .wb_ack
	);

endmodule

// File: source/uart_wb_tx.sv
// Wishbone classic, single writes only; tx_count of zero is not supported
`timescale 1ns/1ps
module uart_wb_tx (
	input logic clk,
	input logic rst,
	input logic tx_start,
	input sensor_pkg::payload_t tx_payload,
	input sensor_pkg::byte_count_t tx_count,
	output logic tx_done,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [2:0] wb_adr,
	output logic [7:0] wb_dat,
	input logic wb_ack
);
	typedef enum logic [1:0] {st_idle, st_bus, st_gap} state_t;

	state_t state;
	sensor_pkg::byte_count_t left; // Bytes after the one on the bus
	sensor_pkg::payload_t shift;

	assign wb_adr = sensor_pkg::uart_tx_adr; // Always the data register

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
			left <= '0;
			tx_done <= 1'b0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			case (state)
				st_idle: if (tx_start) begin
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we <= 1'b1;
					left <= tx_count - 4'd1;
					state <= st_bus;
				end
				st_bus: if (wb_ack) begin
					wb_cyc <= 1'b0; // Bus released between bytes
					wb_stb <= 1'b0;
					wb_we <= 1'b0;
					if (left == '0) begin
						tx_done <= 1'b1;
						state <= st_idle;
					end else state <= st_gap;
				end
				st_gap: begin
					wb_cyc <= 1'b1;
					wb_stb <= 1'b1;
					wb_we <= 1'b1;
					left <= left - 4'd1;
					state <= st_bus;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// MSB first
	always_ff @(posedge clk) begin
		if (state == st_idle && tx_start) begin
			wb_dat <= tx_payload[79:72];
			shift <= {tx_payload[71:0], 8'h00};
		end else if (state == st_gap) begin
			wb_dat <= shift[79:72];
			shift <= {shift[71:0], 8'h00};
		end
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc);

endmodule

// File: source/ecg_port.sv
// RDATAC and SDATAC need no busy phase; a frame not yet taken is overwritten by the next one
`timescale 1ns/1ps
module ecg_port (
	input logic clk,
	input logic rst,
	input logic ecg_wr_req,
	input logic ecg_start,
	input logic ecg_stop,
	input sensor_pkg::reg_addr_t ecg_addr,
	input sensor_pkg::reg_data_t ecg_data,
	input logic frame_taken,
	output logic ecg_done,
	output logic frame_pending,
	output sensor_pkg::ecg_frame_t frame,
	output sensor_pkg::ads_cmd_t ads_cmd,
	output sensor_pkg::reg_addr_t ads_addr,
	output sensor_pkg::reg_data_t ads_wdata,
	input logic ads_busy,
	input sensor_pkg::ecg_frame_t ads_frame,
	input logic ads_ready
);
	typedef enum logic [1:0] {st_idle, st_cmd, st_wait} state_t;

	state_t state;
	logic ready_q;
	logic ready_rise; // One per new frame

	assign ready_rise = ads_ready && !ready_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
			ads_cmd <= sensor_pkg::cmd_idle;
			ads_addr <= '0;
			ads_wdata <= '0;
			ecg_done <= 1'b0;
			ready_q <= 1'b0;
			frame_pending <= 1'b0;
		end else begin
			ready_q <= ads_ready;
			ecg_done <= 1'b0;
			if (ready_rise) frame_pending <= 1'b1; // New frame beats a same-cycle take
			else if (frame_taken) frame_pending <= 1'b0;
			case (state)
				st_idle: begin
					if (ecg_wr_req) begin
						ads_cmd <= sensor_pkg::cmd_wreg;
						ads_addr <= ecg_addr;
						ads_wdata <= ecg_data;
						state <= st_cmd;
					end else if (ecg_start) begin
						ads_cmd <= sensor_pkg::cmd_rdatac;
						state <= st_cmd;
					end else if (ecg_stop) begin
						ads_cmd <= sensor_pkg::cmd_sdatac;
						state <= st_cmd;
					end
				end
				st_cmd: begin
					ads_cmd <= sensor_pkg::cmd_idle; // Command lasts one cycle
					if (ads_cmd == sensor_pkg::cmd_wreg) state <= st_wait;
					else begin
						ecg_done <= 1'b1;
						state <= st_idle;
					end
				end
				st_wait: if (!ads_busy) begin
					ecg_done <= 1'b1;
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ready_rise) frame <= ads_frame;
	end

endmodule

// File: source/touch_port.sv
// Touch chip must raise busy the cycle after a strobe; fail and rdata are sampled as busy drops
`timescale 1ns/1ps
module touch_port (
	input logic clk,
	input logic rst,
	input logic touch_wr_req,
	input logic touch_rd_req,
	input sensor_pkg::reg_addr_t touch_addr,
	input sensor_pkg::reg_data_t touch_data,
	output logic touch_done,
	output logic touch_ok,
	output logic [15:0] touch_bytes, // {low, 4'h0, high nibble}
	output sensor_pkg::touch_status_t touch_status,
	output logic touch_error,
	output sensor_pkg::reg_addr_t mpr_addr,
	output sensor_pkg::reg_data_t mpr_wdata,
	output logic mpr_write,
	output logic mpr_read,
	input sensor_pkg::reg_data_t mpr_rdata,
	input logic mpr_busy,
	input logic mpr_fail
);
	typedef enum logic [1:0] {st_idle, st_load, st_pulse, st_wait} state_t;

	state_t state;
	logic rd_op; // Status pair read
	logic rd_hi; // On the second register
	logic xfer_end;
	logic read_ok;
	sensor_pkg::reg_data_t lo_byte;

	assign xfer_end = (state == st_wait) && !mpr_busy;
	assign read_ok = xfer_end && !mpr_fail && rd_op;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
			rd_op <= 1'b0;
			rd_hi <= 1'b0;
			mpr_addr <= '0;
			mpr_wdata <= '0;
			mpr_write <= 1'b0;
			mpr_read <= 1'b0;
			touch_done <= 1'b0;
			touch_ok <= 1'b0;
			touch_status <= '0;
			touch_error <= 1'b0;
		end else begin
			mpr_write <= 1'b0;
			mpr_read <= 1'b0;
			touch_done <= 1'b0;
			case (state)
				st_idle: if (touch_wr_req || touch_rd_req) begin
					mpr_addr <= touch_rd_req ? sensor_pkg::touch_status_lo : touch_addr;
					mpr_wdata <= touch_data;
					rd_op <= touch_rd_req;
					rd_hi <= 1'b0;
					state <= st_load;
				end
				st_load: begin
					mpr_write <= !rd_op;
					mpr_read <= rd_op;
					state <= st_pulse;
				end
				st_pulse: state <= st_wait; // Busy not up yet
				st_wait: if (!mpr_busy) begin
					if (mpr_fail) begin
						touch_error <= 1'b1; // Sticky until reset
						touch_ok <= 1'b0;
						touch_done <= 1'b1;
						state <= st_idle;
					end else if (rd_op && !rd_hi) begin
						mpr_addr <= sensor_pkg::touch_status_hi; // Next of the pair
						rd_hi <= 1'b1;
						state <= st_load;
					end else begin
						if (rd_op) touch_status <= {mpr_rdata[3:0], lo_byte};
						touch_ok <= 1'b1;
						touch_done <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (read_ok && !rd_hi) lo_byte <= mpr_rdata;
		if (read_ok && rd_hi) touch_bytes <= {lo_byte, 4'h0, mpr_rdata[3:0]};
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(mpr_write && mpr_read));

endmodule

// File: source/sensor_sequencer.sv
// One request in flight at a time; a failed touch poll is dropped and a failed setup write is not retried
`timescale 1ns/1ps
module sensor_sequencer #(
	parameter logic [31:0] touch_poll_cycles = 32'd10000
) (
	input logic clk,
	input logic rst,
	input logic run,
	output logic touch_wr_req,
	output logic touch_rd_req,
	output sensor_pkg::reg_addr_t touch_addr,
	output sensor_pkg::reg_data_t touch_data,
	input logic touch_done,
	input logic touch_ok,
	input logic [15:0] touch_bytes,
	output logic ecg_wr_req,
	output logic ecg_start,
	output logic ecg_stop,
	output sensor_pkg::reg_addr_t ecg_addr,
	output sensor_pkg::reg_data_t ecg_data,
	input logic ecg_done,
	input logic frame_pending,
	input sensor_pkg::ecg_frame_t frame,
	output logic frame_taken,
	output logic tx_start,
	output sensor_pkg::payload_t tx_payload,
	output sensor_pkg::byte_count_t tx_count,
	input logic tx_done,
	output logic ready,
	output logic running
);
	typedef enum logic [3:0] {
		st_setup, st_setup_wait, st_stopped, st_run_ele, st_run_adc,
		st_running, st_poll, st_tx, st_stop_ele, st_stop_adc
	} state_t;

	state_t state;
	logic [4:0] idx; // Setup table entry
	sensor_pkg::reg_addr_t cmd_addr; // Shared by both ports
	sensor_pkg::reg_data_t cmd_data;
	logic [31:0] poll_cnt;
	logic poll_due;

	assign touch_addr = cmd_addr;
	assign touch_data = cmd_data;
	assign ecg_addr = cmd_addr;
	assign ecg_data = cmd_data;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_setup;
			idx <= '0;
			cmd_addr <= '0;
			cmd_data <= '0;
			touch_wr_req <= 1'b0;
			touch_rd_req <= 1'b0;
			ecg_wr_req <= 1'b0;
			ecg_start <= 1'b0;
			ecg_stop <= 1'b0;
			frame_taken <= 1'b0;
			tx_start <= 1'b0;
			tx_payload <= '0;
			tx_count <= '0;
			ready <= 1'b0;
			running <= 1'b0;
		end else begin
			touch_wr_req <= 1'b0; // All requests are single-cycle
			touch_rd_req <= 1'b0;
			ecg_wr_req <= 1'b0;
			ecg_start <= 1'b0;
			ecg_stop <= 1'b0;
			frame_taken <= 1'b0;
			tx_start <= 1'b0;
			case (state)
				st_setup: begin
					cmd_addr <= sensor_pkg::setup_addr(idx);
					cmd_data <= sensor_pkg::setup_data(idx);
					if (idx < 5'(sensor_pkg::touch_setup_len)) touch_wr_req <= 1'b1;
					else ecg_wr_req <= 1'b1; // ADC half of the table
					state <= st_setup_wait;
				end
				st_setup_wait: if (touch_done || ecg_done) begin
					if (idx == 5'(sensor_pkg::setup_len - 1)) begin
						ready <= 1'b1;
						state <= st_stopped;
					end else begin
						idx <= idx + 5'd1;
						state <= st_setup;
					end
				end
				st_stopped: begin
					frame_taken <= frame_pending; // Flush leftovers from the last run
					if (run) begin
						cmd_addr <= sensor_pkg::touch_ele_config;
						cmd_data <= sensor_pkg::ele_run;
						touch_wr_req <= 1'b1;
						state <= st_run_ele;
					end
				end
				st_run_ele: if (touch_done) begin
					ecg_start <= 1'b1; // RDATAC
					state <= st_run_adc;
				end
				st_run_adc: if (ecg_done) begin
					running <= 1'b1;
					state <= st_running;
				end
				st_running: begin
					if (!run) begin
						cmd_addr <= sensor_pkg::touch_ele_config;
						cmd_data <= sensor_pkg::ele_stop;
						touch_wr_req <= 1'b1;
						state <= st_stop_ele;
					end else if (frame_pending) begin // ADC wins over touch
						tx_payload <= {sensor_pkg::hdr_ecg, frame};
						tx_count <= 4'd10;
						tx_start <= 1'b1;
						frame_taken <= 1'b1;
						state <= st_tx;
					end else if (poll_due) begin
						touch_rd_req <= 1'b1;
						state <= st_poll;
					end
				end
				st_poll: if (touch_done) begin
					if (touch_ok) begin
						tx_payload <= {sensor_pkg::hdr_touch, touch_bytes, 56'h0};
						tx_count <= 4'd3;
						tx_start <= 1'b1;
						state <= st_tx;
					end else state <= st_running; // Nothing sent on a failed poll
				end
				st_tx: if (tx_done) state <= st_running;
				st_stop_ele: if (touch_done) begin
					ecg_stop <= 1'b1; // SDATAC
					state <= st_stop_adc;
				end
				st_stop_adc: if (ecg_done) begin
					running <= 1'b0;
					state <= st_stopped;
				end
				default: state <= st_stopped;
			endcase
		end
	end

	// Poll timer, free running while acquisition is on
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			poll_cnt <= '0;
			poll_due <= 1'b0;
		end else if (!running) begin
			poll_cnt <= '0;
			poll_due <= 1'b0;
		end else begin
			if (touch_rd_req) poll_due <= 1'b0;
			if (poll_cnt == touch_poll_cycles - 32'd1) begin
				poll_cnt <= '0;
				poll_due <= 1'b1;
			end else poll_cnt <= poll_cnt + 32'd1;
		end
	end

	a_tx_alone: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> !(touch_wr_req || touch_rd_req || ecg_wr_req || ecg_start || ecg_stop));

endmodule

// File: source/sensor_pkg.sv
// Fixed MPR121/ADS1292 register values, 25 setup writes; the UART data register sits at offset 0
package sensor_pkg;

	typedef logic [7:0] reg_addr_t; // Sensor register address
	typedef logic [7:0] reg_data_t; // Sensor register value
	typedef logic [71:0] ecg_frame_t; // Status word plus two 24-bit channels
	typedef logic [11:0] touch_status_t; // One bit per electrode
	typedef logic [79:0] payload_t; // Header plus up to 9 bytes, left aligned
	typedef logic [3:0] byte_count_t;

	// Control codes toward the ADC SPI engine
	typedef enum logic [2:0] {
		cmd_idle = 3'b000,
		cmd_wreg = 3'b010,
		cmd_rdatac = 3'b100,
		cmd_sdatac = 3'b101
	} ads_cmd_t;

	localparam logic [7:0] hdr_ecg = 8'hA5; // Host tells frame kinds apart by these
	localparam logic [7:0] hdr_touch = 8'h5A;

	localparam reg_addr_t touch_status_lo = 8'h00; // ELE0..ELE7
	localparam reg_addr_t touch_status_hi = 8'h01; // ELE8..ELE11 in low nibble
	localparam reg_addr_t touch_ele_config = 8'h5E;
	localparam reg_data_t ele_run = 8'h8F; // All 12 electrodes on
	localparam reg_data_t ele_stop = 8'h00;

	localparam logic [2:0] uart_tx_adr = 3'd0;

	localparam int setup_len = 25;
	localparam int touch_setup_len = 14; // Touch chip entries come first

	// Packed {address, value} per entry
	function automatic logic [15:0] setup_entry(input logic [4:0] idx);
		case (idx)
			5'd0: return {8'h2B, 8'h01}; // Baseline filter, rising
			5'd1: return {8'h2C, 8'h01};
			5'd2: return {8'h2D, 8'h0E};
			5'd3: return {8'h2E, 8'h00};
			5'd4: return {8'h2F, 8'h01}; // Falling
			5'd5: return {8'h30, 8'h05};
			5'd6: return {8'h31, 8'h01};
			5'd7: return {8'h32, 8'h00};
			5'd8: return {8'h33, 8'h00}; // Touched
			5'd9: return {8'h34, 8'h00};
			5'd10: return {8'h35, 8'h00};
			5'd11: return {8'h5B, 8'h00}; // Debounce
			5'd12: return {8'h5C, 8'h10}; // CDC config
			5'd13: return {8'h5D, 8'h20}; // CDT config
			5'd14: return {8'h01, 8'h02}; // ADC CONFIG1
			5'd15: return {8'h02, 8'hA0};
			5'd16: return {8'h03, 8'h10}; // LOFF
			5'd17: return {8'h04, 8'h81}; // CH1SET
			5'd18: return {8'h05, 8'h00}; // CH2SET
			5'd19: return {8'h06, 8'h63};
			5'd20: return {8'h07, 8'h0F};
			5'd21: return {8'h08, 8'h40};
			5'd22: return {8'h09, 8'hEA}; // RESP1
			5'd23: return {8'h0A, 8'h03};
			5'd24: return {8'h0B, 8'h00}; // GPIO
			default: return 16'h0000;
		endcase
	endfunction

	function automatic reg_addr_t setup_addr(input logic [4:0] idx);
		logic [15:0] entry;
		entry = setup_entry(idx);
		return entry[15:8];
	endfunction

	function automatic reg_data_t setup_data(input logic [4:0] idx);
		logic [15:0] entry;
		entry = setup_entry(idx);
		return entry[7:0];
	endfunction

endpackage
